// File: hdl/post_norm_pkg.sv
package post_norm_pkg;

	// ------------------------------------------------------------------
	// Field widths
	// ------------------------------------------------------------------
	localparam int EXP_W   = 8;
	localparam int FRACT_W = 23;
	localparam int WIDE_W  = 48;
	localparam int INT_W   = 32;

	localparam int EXP_BIAS = 127;
	localparam int EXP_INF  = 255;
	// Biased exponent of an integer with its top bit set
	localparam int I2F_EXP_BASE = EXP_BIAS + INT_W - 1;

	// Operation select
	localparam logic OP_ADD_SUB = 1'b0;
	localparam logic OP_I2F     = 1'b1;

	// Rounding modes
	localparam logic [1:0] RM_NEAREST = 2'd0;
	localparam logic [1:0] RM_ZERO    = 2'd1;
	localparam logic [1:0] RM_UP      = 2'd2;
	localparam logic [1:0] RM_DOWN    = 2'd3;

	// Add/subtract view, binary point after fract bit 46, bit 47 is the carry
	typedef struct packed {
		logic [EXP_W-1:0]  exp;
		logic [WIDE_W-1:0] fract;
	} asub_view_t;

	// Integer view, magnitude in the low bits
	typedef struct packed {
		logic [EXP_W+WIDE_W-INT_W-1:0] pad;
		logic [INT_W-1:0]              mag;
	} conv_view_t;

	typedef union packed {
		asub_view_t asub;
		conv_view_t conv;
	} norm_word_u;

endpackage

// File: testbench/post_norm_model.sv
package post_norm_model;

	// Biased exponent of bit 31 of an integer magnitude
	localparam int CONV_TOP_EXP = 158;
	localparam int MAX_EXP      = 255;

	// Expected {word, inexact, overflow, underflow} for one operation
	function automatic logic [34:0] expected_result(
		input logic        op_i2f,
		input logic        sign,
		input logic [1:0]  rmode,
		input logic [55:0] operand
	);
		logic [47:0] wide;
		logic [24:0] sig;
		logic        rnd;
		logic        stk;
		logic        up;
		logic        inex;
		logic        unf;
		logic        to_inf;
		int          top_exp;
		int          lead;
		int          top;
		int          e;
		int          k;

		// Biased exponent that bit 47 of the wide field stands for
		if (op_i2f)
		begin
			wide    = {operand[31:0], 16'h0};
			top_exp = CONV_TOP_EXP;
		end
		else
		begin
			wide    = operand[47:0];
			top_exp = int'(operand[55:48]) + 1;
		end

		if (wide == '0)
			return {sign, 31'h0, 3'b000};

		lead = 0;
		for (int i = 0; i < 48; i++)
		begin
			if (wide[i])
				lead = i;
		end

		// Normal when the leading one keeps a positive exponent
		e = top_exp - (47 - lead);
		if (e >= 1)
			top = lead;
		else
		begin
			top = 48 - top_exp;
			e   = 0;
		end

		sig = '0;
		rnd = 1'b0;
		stk = 1'b0;
		for (int i = 0; i < 48; i++)
		begin
			k = top - i;
			if (k >= 0 && k < 24)
				sig[23-k] = wide[i];
			else if (k == 24)
				rnd = wide[i];
			else if (k > 24)
				stk = stk | wide[i];
		end

		case (rmode)
			2'd0:    up = rnd & (stk | sig[0]);
			2'd2:    up = (rnd | stk) & !sign;
			2'd3:    up = (rnd | stk) & sign;
			default: up = 1'b0;
		endcase
		inex = rnd | stk;
		unf  = (e == 0) && inex;

		sig = sig + 25'(up);
		if (sig[24])
		begin
			e   = e + 1;
			sig = sig >> 1;
		end
		else if (e == 0 && sig[23])
			e = 1;

		if (e >= MAX_EXP)
		begin
			to_inf = (rmode == 2'd0) || (rmode == 2'd2 && !sign) || (rmode == 2'd3 && sign);
			if (to_inf)
				return {sign, 8'hff, 23'h0, 3'b110};
			return {sign, 8'hfe, 23'h7f_ffff, 3'b110};
		end
		return {sign, 8'(e), sig[22:0], inex, 1'b0, unf};
	endfunction

endpackage

// File: hdl/norm_shifter.sv
`timescale 1ns/10ps

module norm_shifter (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              in_valid,
	input  logic                              op,
	input  logic                              sign,
	input  logic [1:0]                        rmode,
	input  post_norm_pkg::norm_word_u          operand,
	output logic                              s1_valid,
	output logic                              s1_sign,
	output logic [1:0]                        s1_rmode,
	output logic [post_norm_pkg::EXP_W-1:0]   s1_exp,
	output logic [post_norm_pkg::FRACT_W:0]   s1_fract,
	output logic                              s1_round_bit,
	output logic                              s1_sticky
);
	import post_norm_pkg::*;

	localparam int LZ_W  = $clog2(WIDE_W + 1);
	// Bit position of the round bit after normalisation
	localparam int RND_POS = WIDE_W - FRACT_W - 2;

	logic [WIDE_W-1:0] wide;
	logic [9:0]        tgt_exp;
	logic [LZ_W-1:0]   lz;
	logic [LZ_W-1:0]   shift_amt;
	logic [WIDE_W-1:0] shifted;
	logic              mag_zero;
	logic              normal;
	logic [EXP_W-1:0]  exp_next;

	// ------------------------------------------------------------------
	// Leading zero count and target exponent
	// ------------------------------------------------------------------
	always_comb
	begin
		wide    = operand.asub.fract;
		tgt_exp = '0;
		case (op)
			OP_I2F:
			begin
				// Integer goes to the top of the wide field
				wide = {operand.conv.mag, {(WIDE_W - INT_W){1'b0}}};
			end
			OP_ADD_SUB:
			begin
				wide = operand.asub.fract;
			end
		endcase

		lz = LZ_W'(WIDE_W);
		for (int i = 0; i < WIDE_W; i++)
		begin
			if (wide[i])
				lz = LZ_W'(WIDE_W - 1 - i);
		end

		if (op == OP_I2F)
			tgt_exp = 10'(I2F_EXP_BASE) - {{(10 - LZ_W){1'b0}}, lz};
		else
			tgt_exp = {2'b00, operand.asub.exp} + 10'd1 - {{(10 - LZ_W){1'b0}}, lz};
	end

	assign mag_zero = ~|wide;
	// Negative or zero target means the result stays denormal
	assign normal   = !tgt_exp[9] && (tgt_exp != 10'd0);

	// ------------------------------------------------------------------
	// Normalising shift
	// ------------------------------------------------------------------
	always_comb
	begin
		if (mag_zero)
			shift_amt = '0;
		else if (normal)
			shift_amt = lz;
		else
			// Stop the shift where the exponent reaches the denormal range
			shift_amt = LZ_W'(operand.asub.exp);

		shifted = wide << shift_amt;

		if (mag_zero || !normal)
			exp_next = '0;
		else if (tgt_exp[8])
			exp_next = EXP_W'(EXP_INF);
		else
			exp_next = tgt_exp[EXP_W-1:0];
	end

	// ------------------------------------------------------------------
	// Stage 1 register
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		s1_sign      <= sign;
		s1_rmode     <= rmode;
		s1_exp       <= exp_next;
		s1_fract     <= shifted[WIDE_W-1 -: FRACT_W + 1];
		s1_round_bit <= shifted[RND_POS];
		s1_sticky    <= |shifted[RND_POS-1:0];
	end

	// A normal exponent always carries the hidden bit
	assert property (@(posedge clk) disable iff (reset)
		s1_valid && (s1_exp != '0) |-> s1_fract[FRACT_W]);

endmodule

// File: hdl/round_unit.sv
`timescale 1ns/10ps

module round_unit (
	input  logic                              s1_sign,
	input  logic [1:0]                        s1_rmode,
	input  logic [post_norm_pkg::EXP_W-1:0]   s1_exp,
	input  logic [post_norm_pkg::FRACT_W:0]   s1_fract,
	input  logic                              s1_round_bit,
	input  logic                              s1_sticky,
	output logic [post_norm_pkg::EXP_W:0]     rnd_exp,
	output logic [post_norm_pkg::FRACT_W-1:0] rnd_fract
);
	import post_norm_pkg::*;

	logic             round_up;
	logic [FRACT_W+1:0] sum;
	logic             exp_inc;

	// Round-up decision per mode
	always_comb
	begin
		case (s1_rmode)
			RM_NEAREST: round_up = s1_round_bit & (s1_sticky | s1_fract[0]);
			RM_ZERO:    round_up = 1'b0;
			RM_UP:      round_up = (s1_round_bit | s1_sticky) & !s1_sign;
			RM_DOWN:    round_up = (s1_round_bit | s1_sticky) & s1_sign;
			default:    round_up = 1'b0;
		endcase
	end

	assign sum = {1'b0, s1_fract} + {{(FRACT_W + 1){1'b0}}, round_up};

	// Carry out of the significand, or a denormal gaining its hidden bit
	assign exp_inc = sum[FRACT_W+1] | ((s1_exp == '0) & sum[FRACT_W]);

	assign rnd_exp   = {1'b0, s1_exp} + {{EXP_W{1'b0}}, exp_inc};
	// On carry the stored fraction is zero either way
	assign rnd_fract = sum[FRACT_W-1:0];

endmodule

// File: hdl/exception_unit.sv
`timescale 1ns/10ps

module exception_unit (
	input  logic                            s1_sign,
	input  logic [1:0]                      s1_rmode,
	input  logic [post_norm_pkg::EXP_W-1:0] s1_exp,
	input  logic                            s1_round_bit,
	input  logic                            s1_sticky,
	output logic                            pre_inexact,
	output logic                            pre_underflow,
	output logic                            ovf_to_inf
);
	import post_norm_pkg::*;

	assign pre_inexact = s1_round_bit | s1_sticky;

	// Tininess detected before rounding
	assign pre_underflow = (s1_exp == '0) & pre_inexact;

	// ------------------------------------------------------------------
	// Overflow target, infinity or the largest finite number
	// ------------------------------------------------------------------
	always_comb
	begin
		case (s1_rmode)
			RM_NEAREST: ovf_to_inf = 1'b1;
			RM_ZERO:    ovf_to_inf = 1'b0;
			RM_UP:      ovf_to_inf = !s1_sign;
			RM_DOWN:    ovf_to_inf = s1_sign;
			default:    ovf_to_inf = 1'b1;
		endcase
	end

endmodule

// File: hdl/result_pack.sv
`timescale 1ns/10ps

module result_pack (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              s1_valid,
	input  logic                              s1_sign,
	input  logic [post_norm_pkg::EXP_W:0]     rnd_exp,
	input  logic [post_norm_pkg::FRACT_W-1:0] rnd_fract,
	input  logic                              pre_inexact,
	input  logic                              pre_underflow,
	input  logic                              ovf_to_inf,
	output logic                              s2_valid,
	output logic [31:0]                       s2_word,
	output logic                              s2_inexact,
	output logic                              s2_overflow,
	output logic                              s2_underflow
);
	import post_norm_pkg::*;

	logic        ovf;
	logic [31:0] word_next;

	assign ovf = (rnd_exp >= (EXP_W + 1)'(EXP_INF));

	// Final word selection
	always_comb
	begin
		if (!ovf)
			word_next = {s1_sign, rnd_exp[EXP_W-1:0], rnd_fract};
		else if (ovf_to_inf)
			word_next = {s1_sign, EXP_W'(EXP_INF), {FRACT_W{1'b0}}};
		else
			word_next = {s1_sign, EXP_W'(EXP_INF - 1), {FRACT_W{1'b1}}};
	end

	// ------------------------------------------------------------------
	// Stage 2 register
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		s2_word      <= word_next;
		s2_inexact   <= pre_inexact | ovf;
		s2_overflow  <= ovf;
		s2_underflow <= pre_underflow;
	end

endmodule

// File: hdl/result_queue.sv
`timescale 1ns/10ps

module result_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        s2_valid,
	input  logic [31:0] s2_word,
	input  logic        s2_inexact,
	input  logic        s2_overflow,
	input  logic        s2_underflow,
	input  logic        out_credit,
	output logic        in_credit,
	output logic        out_valid,
	output logic [31:0] out_word,
	output logic        inexact,
	output logic        overflow,
	output logic        underflow
);

	localparam int PTR_W    = $clog2(QUEUE_DEPTH);
	localparam int CNT_W    = $clog2(QUEUE_DEPTH + 1);
	// Room for up to 255 outstanding grants from the receiver
	localparam int CREDIT_W = 8;
	localparam int ENTRY_W  = 35;

	logic [ENTRY_W-1:0]  mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic [CREDIT_W-1:0] credit_cnt;
	logic                pop;

	// Pop whenever an entry and a credit are both present
	assign pop       = (count != '0) && (credit_cnt != '0);
	assign out_valid = pop;
	assign in_credit = pop;

	assign {out_word, inexact, overflow, underflow} = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (s2_valid)
			mem[wr_ptr] <= {s2_word, s2_inexact, s2_overflow, s2_underflow};
	end

	// ------------------------------------------------------------------
	// Pointers, fill level and output credits
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_cnt <= '0;
		end
		else
		begin
			if (s2_valid)
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			case ({s2_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			case ({out_credit, pop})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// Input credits keep the pipeline from overrunning a full queue
	assert property (@(posedge clk) disable iff (reset)
		s2_valid |-> (count != CNT_W'(QUEUE_DEPTH)));

	// Receiver never grants past the counter range
	assert property (@(posedge clk) disable iff (reset)
		out_credit && !pop |-> (credit_cnt != {CREDIT_W{1'b1}}));

endmodule

// File: hdl/post_norm_top.sv
`timescale 1ns/10ps

module post_norm_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  logic                     op,
	input  logic                     sign,
	input  logic [1:0]               rmode,
	input  post_norm_pkg::norm_word_u operand,
	input  logic                     out_credit,
	output logic                     in_credit,
	output logic                     out_valid,
	output logic [31:0]              out_word,
	output logic                     inexact,
	output logic                     overflow,
	output logic                     underflow
);
	import post_norm_pkg::*;

	// Stage 1, normalised value
	logic               s1_valid;
	logic               s1_sign;
	logic [1:0]         s1_rmode;
	logic [EXP_W-1:0]   s1_exp;
	logic [FRACT_W:0]   s1_fract;
	logic               s1_round_bit;
	logic               s1_sticky;

	// Parallel rounding and exception results
	logic [EXP_W:0]     rnd_exp;
	logic [FRACT_W-1:0] rnd_fract;
	logic               pre_inexact;
	logic               pre_underflow;
	logic               ovf_to_inf;

	// Stage 2, packed result
	logic               s2_valid;
	logic [31:0]        s2_word;
	logic               s2_inexact;
	logic               s2_overflow;
	logic               s2_underflow;

	norm_shifter norm_shifter_i (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.op           (op),
		.sign         (sign),
		.rmode        (rmode),
		.operand      (operand),
		.s1_valid     (s1_valid),
		.s1_sign      (s1_sign),
		.s1_rmode     (s1_rmode),
		.s1_exp       (s1_exp),
		.s1_fract     (s1_fract),
		.s1_round_bit (s1_round_bit),
		.s1_sticky    (s1_sticky)
	);

	round_unit round_unit_i (
		.s1_sign      (s1_sign),
		.s1_rmode     (s1_rmode),
		.s1_exp       (s1_exp),
		.s1_fract     (s1_fract),
		.s1_round_bit (s1_round_bit),
		.s1_sticky    (s1_sticky),
		.rnd_exp      (rnd_exp),
		.rnd_fract    (rnd_fract)
	);

	exception_unit exception_unit_i (
		.s1_sign       (s1_sign),
		.s1_rmode      (s1_rmode),
		.s1_exp        (s1_exp),
		.s1_round_bit  (s1_round_bit),
		.s1_sticky     (s1_sticky),
		.pre_inexact   (pre_inexact),
		.pre_underflow (pre_underflow),
		.ovf_to_inf    (ovf_to_inf)
	);

	result_pack result_pack_i (
		.clk           (clk),
		.reset         (reset),
		.s1_valid      (s1_valid),
		.s1_sign       (s1_sign),
		.rnd_exp       (rnd_exp),
		.rnd_fract     (rnd_fract),
		.pre_inexact   (pre_inexact),
		.pre_underflow (pre_underflow),
		.ovf_to_inf    (ovf_to_inf),
		.s2_valid      (s2_valid),
		.s2_word       (s2_word),
		.s2_inexact    (s2_inexact),
		.s2_overflow   (s2_overflow),
		.s2_underflow  (s2_underflow)
	);

	result_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) result_queue_i (
		.clk          (clk),
		.reset        (reset),
		.s2_valid     (s2_valid),
		.s2_word      (s2_word),
		.s2_inexact   (s2_inexact),
		.s2_overflow  (s2_overflow),
		.s2_underflow (s2_underflow),
		.out_credit   (out_credit),
		.in_credit    (in_credit),
		.out_valid    (out_valid),
		.out_word     (out_word),
		.inexact      (inexact),
		.overflow     (overflow),
		.underflow    (underflow)
	);

endmodule

// File: testbench/post_norm_tb.sv
`timescale 1ns/10ps

module post_norm_tb;
	import post_norm_pkg::*;
	import post_norm_model::*;

	localparam int QUEUE_DEPTH = 4;
	localparam int N_ITEMS     = 400 + QUEUE_DEPTH;
	localparam int TIMEOUT     = 20 * N_ITEMS + 200;

	logic                      clk;
	logic                      reset;
	logic                      in_valid;
	logic                      op;
	logic                      sign;
	logic [1:0]                rmode;
	post_norm_pkg::norm_word_u operand;
	logic                      out_credit;
	logic                      in_credit;
	logic                      out_valid;
	logic [31:0]               out_word;
	logic                      inexact;
	logic                      overflow;
	logic                      underflow;

	integer      seed = 32'ha9f68769;
	int          value_errors = 0;
	int          flow_errors = 0;
	int          cycles = 0;
	int          sent = 0;
	int          delivered = 0;
	int          tx_credits = QUEUE_DEPTH;
	int          rx_credits = 0;
	int          grant_mode = 0;
	int          wd_cycles = 0;
	logic        valid_seen = 1'b0;
	logic        credit_given = 1'b0;
	logic        credit_back = 1'b0;
	logic [34:0] expect_q [$];
	int          sent_q [$];
	logic        head_valid = 1'b0;
	logic [34:0] head_entry = '0;
	int          head_age = 0;
	logic [31:0] int_vals [8] = '{32'h0, 32'h1, 32'h2, 32'h0080_0000, 32'h0100_0001,
		32'h0123_4567, 32'h8000_0000, 32'hffff_ffff};

	post_norm_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) dut_i (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.op         (op),
		.sign       (sign),
		.rmode      (rmode),
		.operand    (operand),
		.out_credit (out_credit),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_word   (out_word),
		.inexact    (inexact),
		.overflow   (overflow),
		.underflow  (underflow)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Output checks against the head of the expectation list
	// ------------------------------------------------------------------
	assert property (@(posedge clk) disable iff (reset)
		out_valid |-> head_valid && (out_word == head_entry[34:3]))
	else
	begin
		value_errors++;
		$display("error at %0t: out_word %h, expected %h", $time, $sampled(out_word),
			head_entry[34:3]);
	end

	assert property (@(posedge clk) disable iff (reset)
		out_valid |-> ({inexact, overflow, underflow} == head_entry[2:0]))
	else
	begin
		value_errors++;
		$display("error at %0t: flags %b, expected %b", $time,
			$sampled({inexact, overflow, underflow}), head_entry[2:0]);
	end

	assert property (@(posedge clk) disable iff (reset) out_valid |-> (head_age >= 3))
	else
	begin
		flow_errors++;
		$display("error at %0t: result came out %0d cycles after it was sent", $time, head_age);
	end

	assert property (@(posedge clk) disable iff (reset) out_valid |-> (rx_credits > 0))
	else
	begin
		flow_errors++;
		$display("error at %0t: out_valid without an output credit", $time);
	end

	assert property (@(posedge clk) disable iff (reset) in_credit == out_valid)
	else
	begin
		flow_errors++;
		$display("error at %0t: in_credit does not follow out_valid", $time);
	end

	// Advance one clock and update the bookkeeping, grants and default drive
	task automatic step();
		logic [31:0] r;
		@(negedge clk);
		cycles++;
		if (valid_seen && expect_q.size() != 0)
		begin
			void'(expect_q.pop_front());
			void'(sent_q.pop_front());
			rx_credits--;
			delivered++;
		end
		if (credit_given)
			rx_credits++;
		if (credit_back)
			tx_credits++;
		valid_seen  = out_valid;
		credit_back = in_credit;
		in_valid    = 1'b0;
		r = $random(seed);
		credit_given = ((grant_mode == 2) || (grant_mode == 1 && r[0])) && (rx_credits < 16);
		out_credit   = credit_given;
		head_valid = expect_q.size() != 0;
		head_entry = head_valid ? expect_q[0] : '0;
		head_age   = head_valid ? cycles - sent_q[0] : 0;
	endtask

	task automatic send_item(input logic op_v, input logic sign_v, input logic [1:0] rm_v,
		input logic [55:0] word_v);
		step();
		while (tx_credits == 0)
			step();
		in_valid = 1'b1;
		op       = op_v;
		sign     = sign_v;
		rmode    = rm_v;
		operand  = word_v;
		tx_credits--;
		expect_q.push_back(expected_result(op_v, sign_v, rm_v, word_v));
		sent_q.push_back(cycles);
		sent++;
	endtask

	// Kind 0 is add/subtract, 1 is integer and 2 is a denormal result
	task automatic send_random(input int kind);
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [47:0] fract;
		logic [7:0]  e;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		fract = {r1[15:0], r2};
		if (kind == 1)
			send_item(OP_I2F, r3[2], r3[1:0], {24'h0, r2 >> r3[7:3]});
		else if (kind == 2)
		begin
			e = 8'd1 + (r3[11:4] % 8'd12);
			// Some denormals come out exact
			if (r3[20])
				fract[41:0] = '0;
			send_item(OP_ADD_SUB, r3[2], r3[1:0],
				{e, fract >> (e + 8'd2 + {4'd0, r3[19:16]})});
		end
		else
		begin
			// Leading one mostly at the carry or the hidden bit position
			if (r3[5:4] == 2'd0)
				fract[47] = 1'b1;
			else if (r3[5:4] == 2'd1)
				fract[47:46] = 2'b01;
			e = 8'd1 + (r3[15:8] % 8'd253);
			send_item(OP_ADD_SUB, r3[2], r3[1:0], {e, fract});
		end
	endtask

	task automatic drain();
		while (delivered != sent || tx_credits != QUEUE_DEPTH)
			step();
	endtask

	initial
	begin
		logic [31:0] r;
		reset      = 1'b1;
		in_valid   = 1'b0;
		op         = OP_ADD_SUB;
		sign       = 1'b0;
		rmode      = 2'd0;
		operand    = '0;
		out_credit = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		grant_mode = 1;
		repeat (120) send_random(0);
		foreach (int_vals[v])
		begin
			for (int s = 0; s < 2; s++)
			begin
				for (int m = 0; m < 4; m++)
					send_item(OP_I2F, 1'(s), 2'(m), {24'h0, int_vals[v]});
			end
		end
		repeat (40) send_random(1);

		// Overflow from the carry bit and from rounding an all-ones fraction
		for (int s = 0; s < 2; s++)
		begin
			for (int m = 0; m < 4; m++)
			begin
				r = $random(seed);
				send_item(OP_ADD_SUB, 1'(s), 2'(m), {8'd254, 1'b1, r, r[14:0]});
				send_item(OP_ADD_SUB, 1'(s), 2'(m), {8'd254, 48'h7fff_ffff_ffff});
			end
		end
		repeat (60) send_random(2);
		drain();

		// Use up leftover grants so the queue can be held back
		grant_mode = 0;
		step();
		while (rx_credits != 0)
		begin
			send_random(0);
			drain();
		end

		// Without grants the sender must run dry after QUEUE_DEPTH items
		repeat (QUEUE_DEPTH) send_random(0);
		repeat (10 * QUEUE_DEPTH) step();
		assert (tx_credits == 0 && delivered == sent - QUEUE_DEPTH)
		else
		begin
			flow_errors++;
			$display("error at %0t: queue did not hold %0d items while credits were withheld",
				$time, QUEUE_DEPTH);
		end
		grant_mode = 2;
		drain();

		grant_mode = 1;
		repeat (80)
		begin
			r = $random(seed);
			send_random(int'(r[1:0]) % 3);
		end
		drain();

		$display("value errors: %0d, flow errors: %0d, items checked: %0d",
			value_errors, flow_errors, delivered);
		if (value_errors == 0 && flow_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial
	begin
		while (wd_cycles < TIMEOUT)
		begin
			@(posedge clk);
			wd_cycles++;
		end
		$display("Timeout: run stopped after %0d cycles, %0d of %0d items came out",
			TIMEOUT, delivered, sent);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: post_norm_top.f
hdl/post_norm_pkg.sv
testbench/post_norm_model.sv
hdl/norm_shifter.sv
hdl/round_unit.sv
hdl/exception_unit.sv
hdl/result_pack.sv
hdl/result_queue.sv
hdl/post_norm_top.sv
testbench/post_norm_tb.sv

// File: Makefile
# Verilator simulation of the post-normalisation stage

VERILATOR ?= verilator
TOP       ?= post_norm_tb
FILELIST  ?= post_norm_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
